// File: common/dcache_pkg.sv
// --------------------
// data cache package
// geometry, vector types, port structs and controller states
// --------------------
`default_nettype none

package dcache_pkg;

    // --------------------
    // geometry
    // --------------------
    localparam int DCACHE_WAYS        = 2;
    localparam int DCACHE_SETS        = 16;
    localparam int DCACHE_LINE_WIDTH  = 128;
    localparam int WORD_WIDTH         = 64;
    localparam int WORDS_PER_LINE     = 2;
    // byte offset within a line, then set bits on top
    localparam int DCACHE_BYTE_OFFSET = 4;
    localparam int DCACHE_INDEX_WIDTH = 8;
    localparam int DCACHE_TAG_WIDTH   = 24;
    localparam int ADDR_WIDTH         = 32;

    // --------------------
    // vector types
    // --------------------
    typedef logic [WORD_WIDTH-1:0]         word_t;
    typedef logic [WORD_WIDTH/8-1:0]       be_t;
    typedef logic [DCACHE_LINE_WIDTH-1:0]  line_t;
    typedef logic [DCACHE_TAG_WIDTH-1:0]   tag_t;
    typedef logic [DCACHE_INDEX_WIDTH-1:0] index_t;
    typedef logic [DCACHE_WAYS-1:0]        way_vec_t;
    typedef logic [ADDR_WIDTH-1:0]         addr_t;

    // --------------------
    // port structs
    // --------------------
    // core request, held by the core until gnt
    typedef struct packed {
        logic   req;
        logic   we;
        be_t    be;
        index_t index;
        tag_t   tag;
        word_t  wdata;
    } core_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } core_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        be_t   be;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } mem_rsp_t;

    // bypass set means one word, otherwise a full line refill
    typedef struct packed {
        logic  valid;
        logic  bypass;
        logic  we;
        addr_t addr;
        be_t   be;
        word_t wdata;
    } miss_req_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_LOOKUP,
        STORE_REQ,
        WAIT_MISS_GNT,
        WAIT_REFILL
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: cache_ctrl/cache_ctrl.sv
// --------------------
// data cache controller
// sequences lookup, store update, refill and bypass for one core port
// --------------------
`default_nettype none

module cache_ctrl (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    input  logic                                       bypass_i,
    input  dcache_pkg::core_req_t                      core_req_i,
    output dcache_pkg::core_rsp_t                      core_rsp_o,
    output logic                                       busy_o,
    output logic                                       hit_o,
    // array side
    output logic                                       arr_req_o,
    output logic                                       arr_we_o,
    output dcache_pkg::way_vec_t                       arr_way_o,
    output dcache_pkg::index_t                         arr_index_o,
    output dcache_pkg::line_t                          arr_wdata_o,
    output logic [dcache_pkg::DCACHE_LINE_WIDTH/8-1:0] arr_be_o,
    input  logic                                       arr_hit_i,
    input  dcache_pkg::line_t                          arr_line_i,
    // miss unit side
    output dcache_pkg::miss_req_t                      miss_req_o,
    input  logic                                       miss_gnt_i,
    input  logic                                       miss_done_i,
    input  dcache_pkg::line_t                          refill_line_i
);
    import dcache_pkg::*;

    ctrl_state_e state_q, state_d;
    core_req_t   req_q, req_d;
    logic        bypass_q, bypass_d;
    // which 64-bit word of the line the access targets
    logic [$clog2(WORDS_PER_LINE)-1:0] word_off;

    function automatic word_t pick_word(line_t line, logic [$clog2(WORDS_PER_LINE)-1:0] off);
        return line[off*WORD_WIDTH +: WORD_WIDTH];
    endfunction

    assign busy_o   = (state_q != IDLE);
    assign word_off = req_q.index[DCACHE_BYTE_OFFSET-1:3];

    // --------------------
    // controller FSM
    // --------------------
    always_comb begin
        state_d    = state_q;
        req_d      = req_q;
        bypass_d   = bypass_q;
        core_rsp_o = '0;
        hit_o      = 1'b0;
        // array defaults, store data replicated into every word slot
        arr_req_o   = 1'b0;
        arr_we_o    = 1'b0;
        arr_way_o   = '0;
        arr_index_o = req_q.index;
        arr_wdata_o = {WORDS_PER_LINE{req_q.wdata}};
        arr_be_o    = '0;
        // stores always go out as single words
        miss_req_o.valid  = 1'b0;
        miss_req_o.bypass = bypass_q | req_q.we;
        miss_req_o.we     = req_q.we;
        miss_req_o.addr   = {req_q.tag, req_q.index};
        miss_req_o.be     = req_q.be;
        miss_req_o.wdata  = req_q.wdata;

        case (state_q)
            IDLE: begin
                if (core_req_i.req) begin
                    req_d    = core_req_i;
                    bypass_d = bypass_i;
                    // loads are accepted at once, stores granted on completion
                    core_rsp_o.gnt = !core_req_i.we;
                    if (bypass_i) begin
                        state_d = WAIT_MISS_GNT;
                    end else begin
                        // speculative array read in the accept cycle
                        arr_req_o   = 1'b1;
                        arr_index_o = core_req_i.index;
                        state_d     = WAIT_LOOKUP;
                    end
                end
            end

            WAIT_LOOKUP: begin
                if (arr_hit_i) begin
                    hit_o = 1'b1;
                    if (req_q.we) begin
                        state_d = STORE_REQ;
                    end else begin
                        core_rsp_o.rvalid = 1'b1;
                        core_rsp_o.rdata  = pick_word(arr_line_i, word_off);
                        state_d           = IDLE;
                    end
                end else begin
                    // load refills, store goes to memory only
                    state_d = WAIT_MISS_GNT;
                end
            end

            STORE_REQ: begin
                // update the hit way, the array narrows the mask
                arr_req_o = 1'b1;
                arr_we_o  = 1'b1;
                arr_way_o = '1;
                arr_be_o[word_off*(WORD_WIDTH/8) +: WORD_WIDTH/8] = req_q.be;
                // write-through of the same word
                miss_req_o.valid = 1'b1;
                if (miss_done_i) begin
                    core_rsp_o.gnt = 1'b1;
                    state_d        = IDLE;
                end
            end

            WAIT_MISS_GNT: begin
                miss_req_o.valid = 1'b1;
                if (miss_gnt_i) begin
                    if (req_q.we) begin
                        // write done with its memory grant
                        core_rsp_o.gnt = 1'b1;
                        state_d        = IDLE;
                    end else begin
                        state_d = WAIT_REFILL;
                    end
                end
            end

            WAIT_REFILL: begin
                if (miss_done_i) begin
                    core_rsp_o.rvalid = 1'b1;
                    core_rsp_o.rdata  = pick_word(refill_line_i, word_off);
                    // cached loads install the line into the victim way
                    if (!bypass_q) begin
                        arr_req_o   = 1'b1;
                        arr_we_o    = 1'b1;
                        arr_way_o   = '1;
                        arr_wdata_o = refill_line_i;
                        arr_be_o    = '1;
                    end
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            bypass_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            bypass_q <= bypass_d;
        end
    end

    // accepted request payload
    always_ff @(posedge clk_i) begin
        req_q <= req_d;
    end

endmodule

`default_nettype wire

// File: logic/cache_array.sv
// --------------------
// data cache array
// tags, lines and valid bits per way, hit detection and one LRU bit per set
// --------------------
`default_nettype none

module cache_array (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    input  logic                                       req_i,
    input  logic                                       we_i,
    input  dcache_pkg::way_vec_t                       way_i,
    input  dcache_pkg::index_t                         index_i,
    input  dcache_pkg::tag_t                           tag_i,
    input  dcache_pkg::line_t                          wdata_i,
    input  logic [dcache_pkg::DCACHE_LINE_WIDTH/8-1:0] be_i,
    output dcache_pkg::way_vec_t                       hit_way_o,
    output logic                                       hit_o,
    output dcache_pkg::line_t                          line_o,
    output dcache_pkg::way_vec_t                       lru_way_o
);
    import dcache_pkg::*;

    logic  valid_q [DCACHE_WAYS][DCACHE_SETS];
    tag_t  tags_q  [DCACHE_WAYS][DCACHE_SETS];
    line_t lines_q [DCACHE_WAYS][DCACHE_SETS];
    // index of the way to evict next
    logic [DCACHE_SETS-1:0] lru_q;

    logic [$clog2(DCACHE_SETS)-1:0] set_i, set_q;
    tag_t     look_tag_q;
    logic     rd_q;
    way_vec_t wr_way;

    assign set_i     = index_i[DCACHE_INDEX_WIDTH-1:DCACHE_BYTE_OFFSET];
    assign lru_way_o = way_vec_t'(1) << lru_q[set_i];
    // a store lands in the hit way, a refill in the victim
    assign wr_way    = way_i & (hit_o ? hit_way_o : lru_way_o);
    assign hit_o     = |hit_way_o;

    // compare against the tag latched with the read
    always_comb begin
        line_o = '0;
        for (int w = 0; w < DCACHE_WAYS; w++) begin
            hit_way_o[w] = valid_q[w][set_q] && (tags_q[w][set_q] == look_tag_q);
            if (hit_way_o[w]) begin
                line_o = lines_q[w][set_q];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_q       <= 1'b0;
            set_q      <= '0;
            look_tag_q <= '0;
            lru_q      <= '0;
            for (int w = 0; w < DCACHE_WAYS; w++) begin
                for (int s = 0; s < DCACHE_SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                    tags_q[w][s]  <= '0;
                    lines_q[w][s] <= '0;
                end
            end
        end else begin
            rd_q <= req_i && !we_i;
            if (req_i && !we_i) begin
                set_q      <= set_i;
                look_tag_q <= tag_i;
            end
            // the other way becomes the victim
            if (rd_q && hit_o) begin
                lru_q[set_q] <= hit_way_o[0];
            end
            if (req_i && we_i) begin
                lru_q[set_i] <= wr_way[0];
                for (int w = 0; w < DCACHE_WAYS; w++) begin
                    if (wr_way[w]) begin
                        valid_q[w][set_i] <= 1'b1;
                        tags_q[w][set_i]  <= look_tag_q;
                        for (int b = 0; b < DCACHE_LINE_WIDTH/8; b++) begin
                            if (be_i[b]) begin
                                lines_q[w][set_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/miss_unit.sv
// --------------------
// miss unit
// line refills and single-word memory accesses
// --------------------
`default_nettype none

module miss_unit (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  dcache_pkg::miss_req_t miss_req_i,
    output logic                  miss_gnt_o,
    output logic                  miss_done_o,
    output dcache_pkg::line_t     refill_line_o,
    output dcache_pkg::mem_req_t  mem_req_o,
    input  dcache_pkg::mem_rsp_t  mem_rsp_i
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        MU_IDLE,
        MU_REQ,
        MU_DATA
    } mu_state_e;

    mu_state_e state_q, state_d;
    miss_req_t req_q;
    line_t     line_q;
    logic      done_q, done_d;
    logic [$clog2(WORDS_PER_LINE)-1:0] beat_q, beat_d, slot;

    // word aligned address of one slot in the line
    function automatic addr_t word_addr(addr_t a, logic [$clog2(WORDS_PER_LINE)-1:0] w);
        return {a[ADDR_WIDTH-1:DCACHE_BYTE_OFFSET], w, 3'b000};
    endfunction

    // single words return into their own slot
    assign slot          = req_q.bypass ? req_q.addr[DCACHE_BYTE_OFFSET-1:3] : beat_q;
    assign refill_line_o = line_q;

    always_comb begin
        state_d     = state_q;
        beat_d      = beat_q;
        done_d      = 1'b0;
        miss_gnt_o  = 1'b0;
        miss_done_o = done_q;
        mem_req_o   = '0;
        case (state_q)
            MU_IDLE: begin
                // first access goes out straight from the request
                mem_req_o.valid = miss_req_i.valid;
                mem_req_o.we    = miss_req_i.we;
                mem_req_o.addr  = word_addr(miss_req_i.addr, miss_req_i.bypass ?
                                            miss_req_i.addr[DCACHE_BYTE_OFFSET-1:3] : '0);
                mem_req_o.be    = miss_req_i.bypass ? miss_req_i.be : '1;
                mem_req_o.wdata = miss_req_i.wdata;
                if (miss_req_i.valid && mem_rsp_i.gnt) begin
                    miss_gnt_o = 1'b1;
                    beat_d     = '0;
                    if (miss_req_i.we) begin
                        miss_done_o = 1'b1;
                    end else begin
                        state_d = MU_DATA;
                    end
                end
            end
            MU_REQ: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.addr  = word_addr(req_q.addr, beat_q);
                mem_req_o.be    = '1;
                if (mem_rsp_i.gnt) begin
                    state_d = MU_DATA;
                end
            end
            MU_DATA: begin
                if (mem_rsp_i.rvalid) begin
                    if (req_q.bypass || beat_q == WORDS_PER_LINE - 1) begin
                        done_d  = 1'b1;
                        state_d = MU_IDLE;
                    end else begin
                        beat_d  = beat_q + 1'b1;
                        state_d = MU_REQ;
                    end
                end
            end
            default: state_d = MU_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= MU_IDLE;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            beat_q  <= beat_d;
            done_q  <= done_d;
        end
    end

    // request copy and line buffer
    always_ff @(posedge clk_i) begin
        if (miss_gnt_o) begin
            req_q <= miss_req_i;
        end
        if (state_q == MU_DATA && mem_rsp_i.rvalid) begin
            line_q[slot*WORD_WIDTH +: WORD_WIDTH] <= mem_rsp_i.rdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache_top.sv
// --------------------
// blocking data cache top
// controller, array and miss unit
// --------------------
`default_nettype none

module dcache_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  bypass_i,
    input  dcache_pkg::core_req_t core_req_i,
    output dcache_pkg::core_rsp_t core_rsp_o,
    output dcache_pkg::mem_req_t  mem_req_o,
    input  dcache_pkg::mem_rsp_t  mem_rsp_i,
    output logic                  busy_o,
    output logic                  hit_o
);
    import dcache_pkg::*;

    logic      arr_req, arr_we, arr_hit;
    way_vec_t  arr_way;
    index_t    arr_index;
    line_t     arr_wdata, arr_line, refill_line;
    logic [DCACHE_LINE_WIDTH/8-1:0] arr_be;
    miss_req_t miss_req;
    logic      miss_gnt, miss_done;

    cache_ctrl i_cache_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .bypass_i      (bypass_i),
        .core_req_i    (core_req_i),
        .core_rsp_o    (core_rsp_o),
        .busy_o        (busy_o),
        .hit_o         (hit_o),
        .arr_req_o     (arr_req),
        .arr_we_o      (arr_we),
        .arr_way_o     (arr_way),
        .arr_index_o   (arr_index),
        .arr_wdata_o   (arr_wdata),
        .arr_be_o      (arr_be),
        .arr_hit_i     (arr_hit),
        .arr_line_i    (arr_line),
        .miss_req_o    (miss_req),
        .miss_gnt_i    (miss_gnt),
        .miss_done_i   (miss_done),
        .refill_line_i (refill_line)
    );

    // tag comes with the request and is latched on the read
    // hit way and victim way are resolved inside the array
    cache_array i_cache_array (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (arr_req),
        .we_i      (arr_we),
        .way_i     (arr_way),
        .index_i   (arr_index),
        .tag_i     (core_req_i.tag),
        .wdata_i   (arr_wdata),
        .be_i      (arr_be),
        .hit_way_o (),
        .hit_o     (arr_hit),
        .line_o    (arr_line),
        .lru_way_o ()
    );

    miss_unit i_miss_unit (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .miss_req_i    (miss_req),
        .miss_gnt_o    (miss_gnt),
        .miss_done_o   (miss_done),
        .refill_line_o (refill_line),
        .mem_req_o     (mem_req_o),
        .mem_rsp_i     (mem_rsp_i)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// --------------------
// testbench clock and reset
// 8 unit period, reset held low for 5 cycles
// --------------------
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // release on a falling edge, away from the flops
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/dcache_properties.sv
// --------------------
// data cache properties
// core and memory handshake rules, bound into the cache top
// --------------------
`default_nettype none

module dcache_properties (
    input logic                  clk_i,
    input logic                  rst_ni,
    input dcache_pkg::core_req_t core_req_i,
    input dcache_pkg::core_rsp_t core_rsp_i,
    input dcache_pkg::mem_req_t  mem_req_i,
    input dcache_pkg::mem_rsp_t  mem_rsp_i,
    input logic                  busy_i,
    input logic                  hit_i
);

    // number of failed assertions
    int unsigned fail_count = 0;

    // nothing moves while reset is held
    reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !busy_i && !mem_req_i.valid)
        else begin
            fail_count++;
            $error("busy or memory valid high during reset");
        end

    gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_i.gnt |-> core_req_i.req)
        else begin
            fail_count++;
            $error("core grant given without a request");
        end

    // memory request held until granted
    mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_i.valid && !mem_rsp_i.gnt |=> $stable(mem_req_i))
        else begin
            fail_count++;
            $error("memory request changed before its grant");
        end

    // one cycle after a load grant, rvalid comes exactly when the lookup hits
    hit_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_i.gnt && !core_req_i.we |=> hit_i == core_rsp_i.rvalid)
        else begin
            fail_count++;
            $error("load hit and rvalid disagree one cycle after grant");
        end

endmodule

`default_nettype wire

// File: verification/dcache_tb.sv
// --------------------
// data cache testbench
// memory model with random grant delay, load/store stimulus and checks
// --------------------
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int    NUM_TESTS       = 6;
    localparam int    CYCLES_PER_TEST = 200;
    localparam int    WAIT_LIMIT      = 64;
    localparam addr_t ADDR_A  = 32'h0001_2348;
    localparam addr_t ADDR_B  = 32'h0004_5670;
    // three tags that share set 2
    localparam addr_t ADDR_C0 = 32'h0010_0020;
    localparam addr_t ADDR_C1 = 32'h0020_0020;
    localparam addr_t ADDR_C2 = 32'h0030_0020;

    logic      clk, rst_n, bypass, busy, hit;
    core_req_t core_req;
    core_rsp_t core_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;

    // memory contents and the expected copy
    word_t  mem_q    [addr_t];
    word_t  shadow_q [addr_t];
    integer seed = 32'h99719797;
    logic   rd_pending;
    word_t  rd_data;
    int     gnt_wait;
    int     checks = 0;
    int     mismatches = 0;
    int     errors = 0;

    tb_clock_gen i_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    dcache_top DUT (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .bypass_i   (bypass),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp),
        .busy_o     (busy),
        .hit_o      (hit)
    );

    bind dcache_top dcache_properties i_dcache_properties (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .core_req_i (core_req_i),
        .core_rsp_i (core_rsp_o),
        .mem_req_i  (mem_req_o),
        .mem_rsp_i  (mem_rsp_i),
        .busy_i     (busy_o),
        .hit_i      (hit_o)
    );

    // --------------------
    // helpers
    // --------------------
    function automatic addr_t word_key(addr_t a);
        return {a[ADDR_WIDTH-1:3], 3'b000};
    endfunction

    // initial memory content, unique per address
    function automatic word_t fill_word(addr_t a);
        return {a, a ^ 32'h9e37_79b9};
    endfunction

    function automatic word_t mem_word(addr_t a);
        return mem_q.exists(word_key(a)) ? mem_q[word_key(a)] : fill_word(word_key(a));
    endfunction

    function automatic word_t shadow_word(addr_t a);
        return shadow_q.exists(word_key(a)) ? shadow_q[word_key(a)] : fill_word(word_key(a));
    endfunction

    // bytes with their enable set take the new value
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < WORD_WIDTH / 8; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (exp === act) else begin
            mismatches++;
            $display("Mismatch %s %s: expected %h actual %h", name, what, exp, act);
        end
    endtask

    // load, wait for grant and rvalid, then compare data, hit, busy and latency
    task automatic load_word(input string name, input addr_t addr, input logic byp,
                             input word_t exp_data, input logic exp_hit);
        word_t data;
        logic  hit_seen;
        logic  busy_held;
        int    n;
        hit_seen  = 1'b0;
        busy_held = 1'b1;
        data      = '0;
        @(negedge clk);
        bypass         = byp;
        core_req       = '0;
        core_req.req   = 1'b1;
        core_req.be    = '1;
        core_req.index = addr[DCACHE_INDEX_WIDTH-1:0];
        core_req.tag   = addr[ADDR_WIDTH-1:DCACHE_INDEX_WIDTH];
        n = 0;
        do begin
            @(posedge clk);
            n++;
            hit_seen |= hit;
        end while (!core_rsp.gnt && n < WAIT_LIMIT);
        @(negedge clk);
        core_req.req = 1'b0;
        if (n >= WAIT_LIMIT) begin
            errors++;
            $display("%s: load was not granted within %0d cycles", name, WAIT_LIMIT);
            return;
        end
        // cycles from grant to rvalid
        n = 0;
        do begin
            @(posedge clk);
            n++;
            hit_seen  |= hit;
            busy_held &= busy;
            if (core_rsp.rvalid) begin
                data = core_rsp.rdata;
            end
        end while (!core_rsp.rvalid && n < WAIT_LIMIT);
        if (n >= WAIT_LIMIT) begin
            errors++;
            $display("%s: no load data within %0d cycles of the grant", name, WAIT_LIMIT);
            return;
        end
        check_value(name, "rdata", exp_data, data);
        check_value(name, "hit", 64'(exp_hit), 64'(hit_seen));
        // the cache stays busy until the load data is back
        check_value(name, "busy", 64'd1, 64'(busy_held));
        if (exp_hit) begin
            check_value(name, "rvalid latency", 64'd1, 64'(n));
        end
    endtask

    task automatic store_word(input string name, input addr_t addr, input be_t be,
                              input word_t wdata);
        int n;
        @(negedge clk);
        bypass         = 1'b0;
        core_req       = '0;
        core_req.req   = 1'b1;
        core_req.we    = 1'b1;
        core_req.be    = be;
        core_req.index = addr[DCACHE_INDEX_WIDTH-1:0];
        core_req.tag   = addr[ADDR_WIDTH-1:DCACHE_INDEX_WIDTH];
        core_req.wdata = wdata;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!core_rsp.gnt && n < WAIT_LIMIT);
        if (n >= WAIT_LIMIT) begin
            errors++;
            $display("%s: store was not granted within %0d cycles", name, WAIT_LIMIT);
        end
        // write-through, so memory is expected to take every store
        shadow_q[word_key(addr)] = merge_bytes(shadow_word(addr), wdata, be);
        @(negedge clk);
        core_req.req = 1'b0;
    endtask

    // --------------------
    // memory model
    // --------------------
    // grant after 0 to 3 cycles, read data in the cycle after the grant
    initial begin
        mem_rsp    = '0;
        rd_pending = 1'b0;
        rd_data    = '0;
        gnt_wait   = -1;
        forever begin
            @(posedge clk);
            if (mem_rsp.gnt && mem_req.valid) begin
                if (mem_req.we) begin
                    mem_q[mem_req.addr] = merge_bytes(mem_word(mem_req.addr),
                                                      mem_req.wdata, mem_req.be);
                end else begin
                    rd_pending = 1'b1;
                    rd_data    = mem_word(mem_req.addr);
                end
            end
            @(negedge clk);
            mem_rsp.gnt    = 1'b0;
            mem_rsp.rvalid = rd_pending;
            mem_rsp.rdata  = rd_pending ? rd_data : '0;
            rd_pending     = 1'b0;
            if (mem_req.valid) begin
                if (gnt_wait < 0) begin
                    gnt_wait = $random(seed) & 3;
                end
                if (gnt_wait == 0) begin
                    mem_rsp.gnt = 1'b1;
                end
                gnt_wait--;
            end
        end
    end

    // --------------------
    // tests
    // --------------------
    initial begin
        word_t       stale;
        word_t       fresh;
        int unsigned prop_fails;
        core_req = '0;
        bypass   = 1'b0;
        @(posedge rst_n);
        @(posedge clk);
        // idle after reset, then a cold miss
        check_value("reset_state", "busy", 64'd0, 64'(busy));
        check_value("reset_state", "hit", 64'd0, 64'(hit));
        load_word("cold_miss", ADDR_A, 1'b0, shadow_word(ADDR_A), 1'b0);
        load_word("load_hit", ADDR_A, 1'b0, shadow_word(ADDR_A), 1'b1);
        // partial store into a cached word
        store_word("store_hit", ADDR_A, 8'h3c, 64'h1122_3344_5566_7788);
        load_word("store_hit", ADDR_A, 1'b0, shadow_word(ADDR_A), 1'b1);
        check_value("store_hit", "memory", shadow_word(ADDR_A), mem_word(ADDR_A));
        // no write allocate
        store_word("store_miss", ADDR_B, 8'hff, 64'hdead_beef_0bad_f00d);
        load_word("store_miss", ADDR_B, 1'b0, shadow_word(ADDR_B), 1'b0);
        check_value("store_miss", "memory", shadow_word(ADDR_B), mem_word(ADDR_B));
        // third tag in set 2 evicts the least recently used line
        load_word("lru_fill0", ADDR_C0, 1'b0, shadow_word(ADDR_C0), 1'b0);
        load_word("lru_fill1", ADDR_C1, 1'b0, shadow_word(ADDR_C1), 1'b0);
        // a hit on the first line leaves the second one as the oldest
        load_word("lru_touch", ADDR_C0, 1'b0, shadow_word(ADDR_C0), 1'b1);
        load_word("lru_evict", ADDR_C2, 1'b0, shadow_word(ADDR_C2), 1'b0);
        load_word("lru_kept", ADDR_C0, 1'b0, shadow_word(ADDR_C0), 1'b1);
        load_word("lru_reload", ADDR_C1, 1'b0, shadow_word(ADDR_C1), 1'b0);
        // memory changes behind the cache
        stale = shadow_word(ADDR_A);
        fresh = ~stale;
        mem_q[word_key(ADDR_A)]    = fresh;
        shadow_q[word_key(ADDR_A)] = fresh;
        load_word("bypass_on", ADDR_A, 1'b1, fresh, 1'b0);
        load_word("bypass_off", ADDR_A, 1'b0, stale, 1'b1);
        repeat (2) @(posedge clk);
        prop_fails = DUT.i_dcache_properties.fail_count;
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, errors, prop_fails);
        if (mismatches == 0 && errors == 0 && prop_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired, tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/dcache_pkg.sv
cache_ctrl/cache_ctrl.sv
logic/cache_array.sv
logic/miss_unit.sv
logic/dcache_top.sv
verification/tb_clock_gen.sv
verification/dcache_properties.sv
verification/dcache_tb.sv

// File: Makefile
# Verilator build and regression run for the data cache

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
